// File: cu_read_defs.svh
// Sizing constants for the CU read-command controller
// CU count, burst FIFO depth and command field widths

`ifndef CU_READ_DEFS_SVH
`define CU_READ_DEFS_SVH

// Compute units sharing the read path
`define CU_NUM          4
`define CU_ID_WIDTH     2
`define CU_COUNT_WIDTH  3

// Burst command FIFO
`define CMD_FIFO_DEPTH  8
`define CMD_FIFO_ALFULL 6

// Command fields
`define ADDR_WIDTH      32
`define TAG_WIDTH       8

`endif

// File: cu_read_pkg.sv
// Shared types of the CU read-command controller
// Opcodes, issuer FSM states, command and response records

`include "cu_read_defs.svh"

package cu_read_pkg;

	// Kind of memory read
	typedef enum logic {
		READ_LINE    = 1'b0,
		READ_PARTIAL = 1'b1
	} read_opcode_e;

	// Bus issuer FSM
	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		FETCH   = 2'd1,
		REQUEST = 2'd2,
		RELEASE = 2'd3
	} issuer_state_e;

	// One read command as posted by a CU and carried to the bus
	typedef struct packed {
		logic                     valid;
		logic [`CU_ID_WIDTH-1:0]  cu_id;
		read_opcode_e             opcode;
		logic [`ADDR_WIDTH-1:0]   addr;
		logic [`TAG_WIDTH-1:0]    tag;
	} read_cmd_t;

	// Read response from memory
	typedef struct packed {
		logic                     valid;
		logic [`CU_ID_WIDTH-1:0]  cu_id;
		logic [`TAG_WIDTH-1:0]    tag;
		logic                     ok;
	} read_resp_t;

endpackage

// File: read_command_arbiter.sv
// Round-robin arbiter for CU read commands
// Holds the CU enable configuration and pushes one granted command per cycle

`include "cu_read_defs.svh"

module read_command_arbiter
	import cu_read_pkg::*;
(
	input  logic                          clock,
	input  logic                          rstn,
	input  logic [`CU_COUNT_WIDTH-1:0]    cu_count,
	input  logic [`CU_NUM-1:0]            cu_request,
	input  read_cmd_t [`CU_NUM-1:0]       cu_cmd,
	input  logic                          fifo_alfull,
	output logic [`CU_NUM-1:0]            cu_ready,
	output logic [`CU_NUM-1:0]            enable_cu,
	output logic                          push,
	output read_cmd_t                     push_cmd
);

	logic [`CU_COUNT_WIDTH-1:0] cu_count_q;
	logic [`CU_NUM-1:0]         masked_request;
	logic [`CU_ID_WIDTH-1:0]    last_grant;
	logic [`CU_ID_WIDTH-1:0]    grant_idx;
	logic                       grant_found;
	logic                       grant_now;
	read_cmd_t                  sel_cmd;

	//////////////////////////////
	// Enable configuration
	//////////////////////////////

	// Zero count keeps the previous setting
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_count_q <= '0;
			enable_cu  <= '0;
		end else begin
			if (cu_count != '0)
				cu_count_q <= cu_count;
			for (int i = 0; i < `CU_NUM; i++)
				enable_cu[i] <= (i < cu_count_q);
		end
	end

	//////////////////////////////
	// Round-robin selection
	//////////////////////////////

	assign masked_request = cu_request & enable_cu;

	// Search starts just after the last CU served
	always_comb begin
		int cand;
		grant_found = 1'b0;
		grant_idx   = last_grant;
		cand        = 0;
		for (int k = 1; k <= `CU_NUM; k++) begin
			cand = (int'(last_grant) + k) % `CU_NUM;
			if (!grant_found && masked_request[cand]) begin
				grant_found = 1'b1;
				grant_idx   = cand[`CU_ID_WIDTH-1:0];
			end
		end
	end

	// Hold off while the FIFO is nearly full
	assign grant_now = grant_found && !fifo_alfull;

	always_comb begin
		sel_cmd       = cu_cmd[grant_idx];
		sel_cmd.valid = 1'b1;
		sel_cmd.cu_id = grant_idx;
	end

	//////////////////////////////
	// Grant registers
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_ready   <= '0;
			push       <= 1'b0;
			last_grant <= '0;
		end else begin
			cu_ready <= '0;
			push     <= grant_now;
			if (grant_now) begin
				cu_ready[grant_idx] <= 1'b1;
				last_grant          <= grant_idx;
			end
		end
	end

	// Command payload, qualified by push
	always_ff @(posedge clock) begin
		if (grant_now)
			push_cmd <= sel_cmd;
	end

endmodule

// File: burst_command_fifo.sv
// Burst command FIFO between the arbiter and the bus issuer
// Circular buffer with registered read port and almost-full flag

`include "cu_read_defs.svh"

module burst_command_fifo
	import cu_read_pkg::*;
(
	input  logic       clock,
	input  logic       rstn,
	input  logic       push,
	input  read_cmd_t  push_cmd,
	input  logic       pop,
	output read_cmd_t  pop_cmd,
	output logic       empty,
	output logic       alfull
);

	localparam int PTR_W = $clog2(`CMD_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`CMD_FIFO_DEPTH + 1);

	read_cmd_t        mem [`CMD_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push_ok;
	logic             pop_ok;

	assign push_ok = push && (count != CNT_W'(`CMD_FIFO_DEPTH));
	assign pop_ok  = pop && !empty;

	assign empty = (count == '0);
	// A push in flight already counts as an entry
	assign alfull = (32'(count) + 32'(push)) >= `CMD_FIFO_ALFULL;

	//////////////////////////////
	// Pointers and fill level
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= (wr_ptr == PTR_W'(`CMD_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == PTR_W'(`CMD_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (push_ok)
			mem[wr_ptr] <= push_cmd;
	end

	// Popped entry shows up the cycle after pop
	always_ff @(posedge clock) begin
		if (pop_ok)
			pop_cmd <= mem[rd_ptr];
	end

endmodule

// File: bus_command_issuer.sv
// Memory bus command issuer
// Pulls commands from the burst FIFO and runs a four-phase req/ack transfer

module bus_command_issuer
	import cu_read_pkg::*;
(
	input  logic       clock,
	input  logic       rstn,
	input  logic       fifo_empty,
	output logic       pop,
	input  read_cmd_t  pop_cmd,
	output logic       bus_req,
	output read_cmd_t  bus_cmd,
	input  logic       bus_ack
);

	issuer_state_e state;

	// Only pop when nothing is in flight
	assign pop = (state == IDLE) && !fifo_empty;

	//////////////////////////////
	// Issuer FSM
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state   <= IDLE;
			bus_req <= 1'b0;
			bus_cmd <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (!fifo_empty)
						state <= FETCH;
				end

				// FIFO output is valid now
				FETCH: begin
					bus_cmd <= pop_cmd;
					state   <= REQUEST;
				end

				// bus_cmd settled one cycle before req goes up
				REQUEST: begin
					if (!bus_req) begin
						bus_req <= 1'b1;
					end else if (bus_ack) begin
						bus_req <= 1'b0;
						state   <= RELEASE;
					end
				end

				// Wait out the ack before the next transfer
				RELEASE: begin
					if (!bus_ack)
						state <= IDLE;
				end

				default: begin
					state   <= IDLE;
					bus_req <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: read_response_router.sv
// Read response router
// Registers each memory response into the slot of the CU it belongs to

`include "cu_read_defs.svh"

module read_response_router
	import cu_read_pkg::*;
(
	input  logic                      clock,
	input  logic                      rstn,
	input  read_resp_t                mem_resp,
	output read_resp_t [`CU_NUM-1:0]  cu_resp
);

	logic [`CU_NUM-1:0] slot_hit;

	// One-hot decode of the target CU
	always_comb begin
		for (int i = 0; i < `CU_NUM; i++)
			slot_hit[i] = mem_resp.valid && (mem_resp.cu_id == `CU_ID_WIDTH'(i));
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_resp <= '0;
		end else begin
			for (int i = 0; i < `CU_NUM; i++) begin
				// Other slots only lose their valid bit
				cu_resp[i].valid <= slot_hit[i];
				if (slot_hit[i]) begin
					cu_resp[i].cu_id <= mem_resp.cu_id;
					cu_resp[i].tag   <= mem_resp.tag;
					cu_resp[i].ok    <= mem_resp.ok;
				end
			end
		end
	end

endmodule

// File: vertex_cu_read_control.sv
// Vertex CU read-command controller, top level
// Arbiter, burst FIFO and bus issuer on the command path, router on responses

`include "cu_read_defs.svh"

module vertex_cu_read_control
	import cu_read_pkg::*;
(
	input  logic                          clock,
	input  logic                          rstn,
	input  logic [`CU_COUNT_WIDTH-1:0]    cu_count,
	input  logic [`CU_NUM-1:0]            cu_request,
	input  read_cmd_t [`CU_NUM-1:0]       cu_cmd,
	output logic [`CU_NUM-1:0]            cu_ready,
	output logic [`CU_NUM-1:0]            enable_cu,
	output logic                          bus_req,
	output read_cmd_t                     bus_cmd,
	input  logic                          bus_ack,
	input  read_resp_t                    mem_resp,
	output read_resp_t [`CU_NUM-1:0]      cu_resp
);

	logic      fifo_push;
	read_cmd_t fifo_push_cmd;
	logic      fifo_pop;
	read_cmd_t fifo_pop_cmd;
	logic      fifo_empty;
	logic      fifo_alfull;

	//////////////////////////////
	// Command path
	//////////////////////////////

	read_command_arbiter u_arbiter (
		.clock       (clock),
		.rstn        (rstn),
		.cu_count    (cu_count),
		.cu_request  (cu_request),
		.cu_cmd      (cu_cmd),
		.fifo_alfull (fifo_alfull),
		.cu_ready    (cu_ready),
		.enable_cu   (enable_cu),
		.push        (fifo_push),
		.push_cmd    (fifo_push_cmd)
	);

	burst_command_fifo u_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (fifo_push),
		.push_cmd (fifo_push_cmd),
		.pop      (fifo_pop),
		.pop_cmd  (fifo_pop_cmd),
		.empty    (fifo_empty),
		.alfull   (fifo_alfull)
	);

	bus_command_issuer u_issuer (
		.clock      (clock),
		.rstn       (rstn),
		.fifo_empty (fifo_empty),
		.pop        (fifo_pop),
		.pop_cmd    (fifo_pop_cmd),
		.bus_req    (bus_req),
		.bus_cmd    (bus_cmd),
		.bus_ack    (bus_ack)
	);

	//////////////////////////////
	// Response path
	//////////////////////////////

	read_response_router u_router (
		.clock    (clock),
		.rstn     (rstn),
		.mem_resp (mem_resp),
		.cu_resp  (cu_resp)
	);

endmodule

// File: tb_vertex_cu_read_control.sv
// Testbench for the vertex CU read-command controller
// Table-driven CU requests, randomized bus ack delays, scoreboard of bus commands

`include "cu_read_defs.svh"

module tb_vertex_cu_read_control
	import cu_read_pkg::*;
();

	localparam int NUM_ROWS   = 10;
	localparam int MAX_CYCLES = NUM_ROWS * 40;

	// One table row of configuration, requests, per-CU command fields and response
	typedef struct packed {
		logic [`CU_COUNT_WIDTH-1:0] count;
		logic [`CU_NUM-1:0]         req;
		logic [`ADDR_WIDTH-1:0]     addr_base;
		logic [`TAG_WIDTH-1:0]      tag_base;
		logic [`CU_NUM-1:0]         ops;
		read_resp_t                 resp;
	} row_t;

	logic                         clock;
	logic                         rstn;
	logic [`CU_COUNT_WIDTH-1:0]   cu_count;
	logic [`CU_NUM-1:0]           cu_request;
	read_cmd_t [`CU_NUM-1:0]      cu_cmd;
	logic [`CU_NUM-1:0]           cu_ready;
	logic [`CU_NUM-1:0]           enable_cu;
	logic                         bus_req;
	read_cmd_t                    bus_cmd;
	logic                         bus_ack;
	read_resp_t                   mem_resp;
	read_resp_t [`CU_NUM-1:0]     cu_resp;

	row_t                         rows [NUM_ROWS];
	read_cmd_t                    exp_q [$];
	logic [31:0]                  lfsr_state;
	int                           cycles;
	int                           pending;
	int                           tb_last;
	int                           cur_row;
	int                           ack_delay;
	logic [`CU_COUNT_WIDTH-1:0]   cnt_model;
	logic [`CU_NUM-1:0]           en_model;
	logic                         prev_bus_req;
	read_cmd_t                    held_cmd;

	vertex_cu_read_control dut (
		.clock      (clock),
		.rstn       (rstn),
		.cu_count   (cu_count),
		.cu_request (cu_request),
		.cu_cmd     (cu_cmd),
		.cu_ready   (cu_ready),
		.enable_cu  (enable_cu),
		.bus_req    (bus_req),
		.bus_cmd    (bus_cmd),
		.bus_ack    (bus_ack),
		.mem_resp   (mem_resp),
		.cu_resp    (cu_resp)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic int draw_ack_delay();
		int d;
		d = 0;
		for (int b = 0; b < 3; b++)
			d = (d << 1) | int'(lfsr_bit());
		return d;
	endfunction

	// Round-robin pick after the last grant or -1 when nobody asks
	function automatic int next_grant(input logic [`CU_NUM-1:0] reqs, input int last);
		int idx;
		int pick;
		pick = -1;
		for (int k = 1; k <= `CU_NUM; k++) begin
			idx = (last + k) % `CU_NUM;
			if (pick < 0 && reqs[idx])
				pick = idx;
		end
		return pick;
	endfunction

	// Command as the CU posts it with the id left at zero
	function automatic read_cmd_t table_cmd(input row_t r, input int i);
		read_cmd_t c;
		c.valid  = 1'b1;
		c.cu_id  = '0;
		c.opcode = read_opcode_e'(r.ops[i]);
		c.addr   = r.addr_base + 32'(i) * 32'd64;
		c.tag    = r.tag_base + 8'(i);
		return c;
	endfunction

	task automatic fail_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_mask(input string name, input logic [`CU_NUM-1:0] exp,
			input logic [`CU_NUM-1:0] act);
		if (exp !== act) begin
			$display("ERR time=%0t %s expected %b actual %b", $time, name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_cmd(input string name, input read_cmd_t exp, input read_cmd_t act);
		if (exp !== act) begin
			$display("ERR time=%0t %s expected %h actual %h", $time, name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_resp(input string name, input read_resp_t exp, input read_resp_t act);
		if (exp !== act) begin
			$display("ERR time=%0t %s expected %h actual %h", $time, name, exp, act);
			fail_run();
		end
	endtask

	//////////////////////////////
	// Per-cycle model and bus responder
	//////////////////////////////

	task automatic tick();
		int                 pick;
		read_cmd_t          exp_cmd;
		logic [`CU_NUM-1:0] en_next;
		logic [`CU_NUM-1:0] valid_mask;
		logic [`CU_NUM-1:0] exp_valid;
		@(negedge clock);
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("Timeout: run went past %0d cycles without finishing", MAX_CYCLES);
			fail_run();
		end
		// Grant seen now answers the requests sampled at the last rising edge
		pick = next_grant(cu_request & en_model, tb_last);
		if (cu_ready != '0 && pending > `CMD_FIFO_ALFULL) begin
			$display("cu_ready went high while the FIFO was almost full");
			fail_run();
		end
		if (cu_ready != '0 || (pick >= 0 && pending < `CMD_FIFO_ALFULL))
			check_mask("cu_ready", (pick < 0) ? '0 : (`CU_NUM'(1) << pick), cu_ready);
		if (cu_ready != '0) begin
			exp_cmd       = table_cmd(rows[cur_row], pick);
			exp_cmd.cu_id = `CU_ID_WIDTH'(pick);
			exp_q.push_back(exp_cmd);
			tb_last = pick;
			pending++;
		end
		for (int i = 0; i < `CU_NUM; i++)
			en_next[i] = (i < int'(cnt_model));
		if (cu_count != '0)
			cnt_model = cu_count;
		en_model = en_next;
		check_mask("enable_cu", en_model, enable_cu);
		// Four-phase rules on the bus
		if (bus_req && !prev_bus_req) begin
			if (bus_ack) begin
				$display("bus_req rose while bus_ack was still high");
				fail_run();
			end
			if (exp_q.size() == 0) begin
				$display("bus command issued with no granted command waiting");
				fail_run();
			end
			check_cmd("bus_cmd", exp_q.pop_front(), bus_cmd);
			held_cmd  = bus_cmd;
			pending--;
			ack_delay = draw_ack_delay();
		end else if (bus_req) begin
			check_cmd("bus_cmd", held_cmd, bus_cmd);
		end
		if (prev_bus_req && !bus_req && !bus_ack) begin
			$display("bus_req fell before bus_ack rose");
			fail_run();
		end
		if (bus_req && !bus_ack) begin
			if (ack_delay == 0)
				bus_ack = 1'b1;
			else
				ack_delay--;
		end else if (!bus_req && bus_ack) begin
			bus_ack = 1'b0;
		end
		prev_bus_req = bus_req;
		// Response routed one cycle after it was driven
		for (int i = 0; i < `CU_NUM; i++)
			valid_mask[i] = cu_resp[i].valid;
		exp_valid = mem_resp.valid ? (`CU_NUM'(1) << mem_resp.cu_id) : '0;
		check_mask("cu_resp valid", exp_valid, valid_mask);
		if (mem_resp.valid)
			check_resp("cu_resp", mem_resp, cu_resp[mem_resp.cu_id]);
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		logic [`CU_NUM-1:0] active;
		int                 held;
		lfsr_state   = 32'hebf4_d24e;
		rstn         = 1'b0;
		cu_count     = '0;
		cu_request   = '0;
		cu_cmd       = '0;
		bus_ack      = 1'b0;
		mem_resp     = '0;
		cycles       = 0;
		pending      = 0;
		tb_last      = 0;
		cur_row      = 0;
		ack_delay    = 0;
		cnt_model    = '0;
		en_model     = '0;
		prev_bus_req = 1'b0;
		held_cmd     = '0;

		// count, requests, address base, tag base, opcodes, response
		rows[0] = '{3'd3, 4'b1111, 32'h1000_0000, 8'h10, 4'b0101, '{1'b1, 2'd1, 8'ha1, 1'b1}};
		rows[1] = '{3'd0, 4'b0111, 32'h1000_1000, 8'h20, 4'b0011, '{1'b1, 2'd0, 8'ha2, 1'b0}};
		rows[2] = '{3'd0, 4'b1010, 32'h1000_2000, 8'h30, 4'b1000, '{1'b0, 2'd0, 8'h00, 1'b0}};
		rows[3] = '{3'd0, 4'b1111, 32'h1000_3000, 8'h40, 4'b1111, '{1'b1, 2'd2, 8'ha4, 1'b1}};
		rows[4] = '{3'd4, 4'b1111, 32'h2000_0000, 8'h50, 4'b0110, '{1'b1, 2'd3, 8'ha5, 1'b1}};
		rows[5] = '{3'd0, 4'b1111, 32'h2000_1000, 8'h60, 4'b1001, '{1'b1, 2'd3, 8'ha6, 1'b0}};
		rows[6] = '{3'd0, 4'b1111, 32'h2000_2000, 8'h70, 4'b0000, '{1'b0, 2'd1, 8'h00, 1'b0}};
		rows[7] = '{3'd0, 4'b0101, 32'h2000_3000, 8'h80, 4'b0100, '{1'b1, 2'd0, 8'ha8, 1'b1}};
		rows[8] = '{3'd0, 4'b1111, 32'h3000_0000, 8'h90, 4'b1010, '{1'b1, 2'd2, 8'ha9, 1'b1}};
		rows[9] = '{3'd0, 4'b1110, 32'h3000_1000, 8'ha0, 4'b0111, '{1'b1, 2'd1, 8'haa, 1'b0}};

		repeat (3) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		check_mask("cu_ready", '0, cu_ready);
		check_mask("enable_cu", '0, enable_cu);
		check_mask("cu_resp valid", '0,
			{cu_resp[3].valid, cu_resp[2].valid, cu_resp[1].valid, cu_resp[0].valid});
		if (bus_req !== 1'b0) begin
			$display("ERR time=%0t bus_req expected 0 actual %b", $time, bus_req);
			fail_run();
		end

		for (int r = 0; r < NUM_ROWS; r++) begin
			cur_row    = r;
			cu_count   = rows[r].count;
			cu_request = rows[r].req;
			for (int i = 0; i < `CU_NUM; i++)
				cu_cmd[i] = table_cmd(rows[r], i);
			mem_resp = rows[r].resp;
			active   = rows[r].req;
			held     = 0;
			// Each CU drops its request after its ready pulse
			do begin
				tick();
				cu_count   = '0;
				mem_resp   = '0;
				active     = active & ~cu_ready;
				cu_request = active;
				held++;
			end while (held < 3 || (active & en_model) != '0);
		end

		cu_request = '0;
		while (exp_q.size() != 0 || bus_req || bus_ack)
			tick();
		repeat (2) tick();

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: project.f
+incdir+.
cu_read_pkg.sv
read_command_arbiter.sv
burst_command_fifo.sv
bus_command_issuer.sv
read_response_router.sv
vertex_cu_read_control.sv
tb_vertex_cu_read_control.sv

// File: Makefile
TOP = tb_vertex_cu_read_control

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -f project.f --top-module $(TOP) -Mdir obj_dir

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
